/* ps_bridge_defs.svh */
// ------------------------------
// bus widths, ack timeout and AXI response codes
// ------------------------------
`ifndef PS_BRIDGE_DEFS_SVH
`define PS_BRIDGE_DEFS_SVH

// bus widths -------------------

// address width, AXI side and system bus side
`define PSB_AXI_AW 32
// data width, strobes are DW/8
`define PSB_AXI_DW 32
// transaction ID width of the GP port
`define PSB_AXI_IW 12

// system bus -------------------

// cycles from the enable pulse before an access is given up
`define PSB_SYS_TIMEOUT 32

// response codes ---------------

`define PSB_RESP_OKAY 2'd0
`define PSB_RESP_SLVERR 2'd2

`endif

/* ps_bridge_pkg.sv */
// ------------------------------
// bridge vector types, AXI and system bus structs, FSM states
// ------------------------------
`default_nettype none

`include "ps_bridge_defs.svh"

package ps_bridge_pkg;

  typedef logic [`PSB_AXI_AW-1:0]   axi_addr_t;  // byte address
  typedef logic [`PSB_AXI_DW-1:0]   axi_data_t;  // one data word
  typedef logic [`PSB_AXI_DW/8-1:0] axi_strb_t;  // byte strobes / byte select
  typedef logic [`PSB_AXI_IW-1:0]   axi_id_t;    // transaction ID
  typedef logic [1:0]               axi_resp_t;  // OKAY / SLVERR

  // AXI channels -----------------
  typedef struct packed {
    axi_id_t   id;    // awid
    axi_addr_t addr;  // awaddr
  } axi_aw_t;

  typedef struct packed {
    axi_data_t data;  // wdata
    axi_strb_t strb;  // wstrb
  } axi_w_t;

  typedef struct packed {
    axi_id_t   id;    // arid
    axi_addr_t addr;  // araddr
  } axi_ar_t;

  // system bus -------------------
  typedef struct packed {
    axi_addr_t addr;   // read/write address
    axi_data_t wdata;  // zero on reads
    axi_strb_t sel;    // byte select
  } sys_req_t;

  typedef struct packed {
    axi_data_t rdata;  // read data
    logic      ack;    // access done
    logic      err;    // valid only with ack
  } sys_rsp_t;

  typedef enum logic [1:0] {IDLE, WRITE, READ, RESP} bridge_state_e;

endpackage

`default_nettype wire

/* axi_req_capture.sv */
// ------------------------------
// one-beat slots for AW, W and AR, plus the issued request register
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi_req_capture
  import ps_bridge_pkg::*;
(
  input  wire      axi_clk_i,     // global clock
  input  wire      reset_i,       // sync, active high
  // write address channel
  input  axi_aw_t  aw_i,
  input  wire      awvalid_i,
  output logic     awready_o,
  // write data channel
  input  axi_w_t   w_i,
  input  wire      wvalid_i,
  output logic     wready_o,
  // read address channel
  input  axi_ar_t  ar_i,
  input  wire      arvalid_i,
  output logic     arready_o,
  // controller side
  input  wire      issue_wr_i,    // move write slots to request reg
  input  wire      issue_rd_i,    // move read slot to request reg
  output logic     wr_pending_o,  // aw and w both held
  output logic     rd_pending_o,  // ar held
  output sys_req_t sys_req_o,     // issued request, stable during access
  output axi_id_t  req_id_o       // ID of the issued request
);

  logic     rdy_en_q;   // low for the first cycle after reset
  logic     aw_full_q;
  logic     w_full_q;
  logic     ar_full_q;
  logic     aw_hs;
  logic     w_hs;
  logic     ar_hs;
  axi_aw_t  aw_q;       // slot payloads
  axi_w_t   w_q;
  axi_ar_t  ar_q;
  sys_req_t req_q;      // issued request
  axi_id_t  id_q;

  // ready whenever the slot is free
  assign awready_o = rdy_en_q & ~aw_full_q;
  assign wready_o  = rdy_en_q & ~w_full_q;
  assign arready_o = rdy_en_q & ~ar_full_q;

  assign aw_hs = awvalid_i & awready_o;  // beat taken this cycle
  assign w_hs  = wvalid_i & wready_o;
  assign ar_hs = arvalid_i & arready_o;

  assign wr_pending_o = aw_full_q & w_full_q;  // write needs both halves
  assign rd_pending_o = ar_full_q;

  assign sys_req_o = req_q;
  assign req_id_o  = id_q;

  // slot flags -------------------
  always_ff @(posedge axi_clk_i) begin
    if (reset_i) begin
      rdy_en_q  <= 1'b0;
      aw_full_q <= 1'b0;
      w_full_q  <= 1'b0;
      ar_full_q <= 1'b0;
    end else begin
      rdy_en_q <= 1'b1;
      // issue only fires on full slots, so no clash with a handshake
      if (issue_wr_i)  aw_full_q <= 1'b0;
      else if (aw_hs)  aw_full_q <= 1'b1;
      if (issue_wr_i)  w_full_q  <= 1'b0;
      else if (w_hs)   w_full_q  <= 1'b1;
      if (issue_rd_i)  ar_full_q <= 1'b0;
      else if (ar_hs)  ar_full_q <= 1'b1;
    end
  end

  // payload ----------------------
  always_ff @(posedge axi_clk_i) begin
    if (aw_hs) aw_q <= aw_i;
    if (w_hs)  w_q  <= w_i;
    if (ar_hs) ar_q <= ar_i;
    if (issue_wr_i) begin
      req_q.addr  <= aw_q.addr;
      req_q.wdata <= w_q.data;
      req_q.sel   <= w_q.strb;   // strobes become byte select
      id_q        <= aw_q.id;
    end else if (issue_rd_i) begin
      req_q.addr  <= ar_q.addr;
      req_q.wdata <= '0;         // nothing to write on a read
      req_q.sel   <= '0;
      id_q        <= ar_q.id;
    end
  end

endmodule

`default_nettype wire

/* axi_bridge_ctrl.sv */
// ------------------------------
// bridge FSM that runs one system bus access at a time
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi_bridge_ctrl
  import ps_bridge_pkg::*;
(
  input  wire  axi_clk_i,     // global clock
  input  wire  reset_i,       // sync active high
  // capture side
  input  wire  wr_pending_i,  // full write waiting
  input  wire  rd_pending_i,  // read waiting
  input  wire  resp_busy_i,   // response not yet accepted
  // system bus answer
  input  wire  sys_ack_i,
  input  wire  sys_err_i,
  input  wire  timeout_i,     // from the ack timer
  // commands
  output logic issue_wr_o,    // pulse that takes the write slots
  output logic issue_rd_o,    // pulse that takes the read slot
  output logic sys_wen_o,     // write enable pulse
  output logic sys_ren_o,     // read enable pulse
  output logic bus_busy_o,    // access outstanding so the timer runs
  output logic resp_load_o,   // pulse that latches the response
  output logic resp_err_o,    // SLVERR for this response
  output logic resp_is_rd_o   // R channel response rather than B
);

  bridge_state_e state_q;
  bridge_state_e state_d;
  logic          access_end;  // ack or timeout this cycle

  assign bus_busy_o = (state_q == WRITE) | (state_q == READ);
  assign access_end = bus_busy_o & (sys_ack_i | timeout_i);

  // a late ack still wins over a timeout in the same cycle
  assign resp_load_o  = access_end;
  assign resp_err_o   = ~sys_ack_i | sys_err_i;
  assign resp_is_rd_o = (state_q == READ);

  // next state -------------------
  always_comb begin
    state_d    = state_q;
    issue_wr_o = 1'b0;
    issue_rd_o = 1'b0;
    case (state_q)
      IDLE: begin
        if (wr_pending_i) begin           // writes first
          issue_wr_o = 1'b1;
          state_d    = WRITE;
        end else if (rd_pending_i) begin
          issue_rd_o = 1'b1;
          state_d    = READ;
        end
      end
      WRITE,
      READ: begin
        if (access_end) state_d = RESP;   // response loads now
      end
      RESP: begin
        if (!resp_busy_i) state_d = IDLE; // hold off until the master takes it
      end
      default: state_d = IDLE;
    endcase
  end

  // state and enables ------------
  always_ff @(posedge axi_clk_i) begin
    if (reset_i) begin
      state_q   <= IDLE;
      sys_wen_o <= 1'b0;
      sys_ren_o <= 1'b0;
    end else begin
      state_q   <= state_d;
      sys_wen_o <= issue_wr_o;  // one cycle after issue
      sys_ren_o <= issue_rd_o;
    end
  end

endmodule

`default_nettype wire

/* sys_bus_timer.sv */
// ------------------------------
// ack timeout counter for the outstanding access
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "ps_bridge_defs.svh"

module sys_bus_timer (
  input  wire  axi_clk_i,   // global clock
  input  wire  reset_i,     // sync, active high
  input  wire  bus_busy_i,  // access outstanding
  output logic timeout_o    // no ack in time
);

  localparam int CNT_W = $clog2(`PSB_SYS_TIMEOUT + 1);

  logic [CNT_W-1:0] cnt_q;  // cycles since the enable pulse

  // zero on the enable cycle, the fsm leaves busy once this fires
  always_ff @(posedge axi_clk_i) begin
    if (reset_i || !bus_busy_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign timeout_o = bus_busy_i & (cnt_q == CNT_W'(`PSB_SYS_TIMEOUT));

endmodule

`default_nettype wire

/* axi_resp_gen.sv */
// ------------------------------
// B and R response registers, held until accepted
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "ps_bridge_defs.svh"

module axi_resp_gen
  import ps_bridge_pkg::*;
(
  input  wire       axi_clk_i,     // global clock
  input  wire       reset_i,       // sync, active high
  // from the controller
  input  wire       resp_load_i,   // access just ended
  input  wire       resp_err_i,    // answer with SLVERR
  input  wire       resp_is_rd_i,  // R channel, else B
  input  axi_id_t   req_id_i,      // ID of the finished access
  input  axi_data_t sys_rdata_i,   // read data from the bus
  // write response channel
  output axi_id_t   bid_o,
  output axi_resp_t bresp_o,
  output logic      bvalid_o,
  input  wire       bready_i,
  // read data channel
  output axi_id_t   rid_o,
  output axi_data_t rdata_o,
  output axi_resp_t rresp_o,
  output logic      rvalid_o,
  input  wire       rready_i,
  output logic      resp_busy_o    // a response is waiting
);

  axi_resp_t code;  // response code for this load

  assign code        = resp_err_i ? `PSB_RESP_SLVERR : `PSB_RESP_OKAY;
  assign resp_busy_o = bvalid_o | rvalid_o;

  // valids -----------------------
  always_ff @(posedge axi_clk_i) begin
    if (reset_i) begin
      bvalid_o <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      if (resp_load_i && !resp_is_rd_i) bvalid_o <= 1'b1;
      else if (bready_i)                bvalid_o <= 1'b0;  // drop after handshake
      if (resp_load_i && resp_is_rd_i)  rvalid_o <= 1'b1;
      else if (rready_i)                rvalid_o <= 1'b0;
    end
  end

  // payload, only loads while idle so it stays put under valid
  always_ff @(posedge axi_clk_i) begin
    if (resp_load_i) begin
      if (resp_is_rd_i) begin
        rid_o   <= req_id_i;
        rresp_o <= code;
        rdata_o <= resp_err_i ? '0 : sys_rdata_i;  // no stale data on error
      end else begin
        bid_o   <= req_id_i;
        bresp_o <= code;
      end
    end
  end

endmodule

`default_nettype wire

/* ps_sys_bridge.sv */
// ------------------------------
// AXI GP slave to system bus bridge, top level
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module ps_sys_bridge
  import ps_bridge_pkg::*;
(
  input  wire       axi_clk_i,  // global clock
  input  wire       reset_i,    // sync, active high
  // AXI write address / data
  input  axi_aw_t   aw_i,
  input  wire       awvalid_i,
  output logic      awready_o,
  input  axi_w_t    w_i,
  input  wire       wvalid_i,
  output logic      wready_o,
  // AXI write response
  output axi_id_t   bid_o,
  output axi_resp_t bresp_o,
  output logic      bvalid_o,
  input  wire       bready_i,
  // AXI read address / data
  input  axi_ar_t   ar_i,
  input  wire       arvalid_i,
  output logic      arready_o,
  output axi_id_t   rid_o,
  output axi_data_t rdata_o,
  output axi_resp_t rresp_o,
  output logic      rvalid_o,
  input  wire       rready_i,
  // system bus
  output sys_req_t  sys_req_o,  // addr, wdata, sel
  output logic      sys_wen_o,  // write enable pulse
  output logic      sys_ren_o,  // read enable pulse
  input  sys_rsp_t  sys_rsp_i   // rdata, ack, err
);

  logic    wr_pending;
  logic    rd_pending;
  logic    issue_wr;
  logic    issue_rd;
  logic    bus_busy;
  logic    timeout;
  logic    resp_load;
  logic    resp_err;
  logic    resp_is_rd;
  logic    resp_busy;
  axi_id_t req_id;     // ID travelling with the access

  axi_req_capture u_capture (
    .axi_clk_i (axi_clk_i), .reset_i (reset_i),
    .aw_i (aw_i), .awvalid_i (awvalid_i), .awready_o (awready_o),
    .w_i (w_i), .wvalid_i (wvalid_i), .wready_o (wready_o),
    .ar_i (ar_i), .arvalid_i (arvalid_i), .arready_o (arready_o),
    .issue_wr_i (issue_wr), .issue_rd_i (issue_rd),
    .wr_pending_o (wr_pending), .rd_pending_o (rd_pending),
    .sys_req_o (sys_req_o), .req_id_o (req_id)
  );

  axi_bridge_ctrl u_ctrl (
    .axi_clk_i (axi_clk_i), .reset_i (reset_i),
    .wr_pending_i (wr_pending), .rd_pending_i (rd_pending), .resp_busy_i (resp_busy),
    .sys_ack_i (sys_rsp_i.ack), .sys_err_i (sys_rsp_i.err), .timeout_i (timeout),
    .issue_wr_o (issue_wr), .issue_rd_o (issue_rd),
    .sys_wen_o (sys_wen_o), .sys_ren_o (sys_ren_o), .bus_busy_o (bus_busy),
    .resp_load_o (resp_load), .resp_err_o (resp_err), .resp_is_rd_o (resp_is_rd)
  );

  sys_bus_timer u_timer (
    .axi_clk_i (axi_clk_i), .reset_i (reset_i),
    .bus_busy_i (bus_busy), .timeout_o (timeout)
  );

  axi_resp_gen u_resp (
    .axi_clk_i (axi_clk_i), .reset_i (reset_i),
    .resp_load_i (resp_load), .resp_err_i (resp_err), .resp_is_rd_i (resp_is_rd),
    .req_id_i (req_id), .sys_rdata_i (sys_rsp_i.rdata),
    .bid_o (bid_o), .bresp_o (bresp_o), .bvalid_o (bvalid_o), .bready_i (bready_i),
    .rid_o (rid_o), .rdata_o (rdata_o), .rresp_o (rresp_o), .rvalid_o (rvalid_o),
    .rready_i (rready_i), .resp_busy_o (resp_busy)
  );

endmodule

`default_nettype wire

/* tb_ps_sys_bridge.sv */
// ------------------------------
// bridge testbench with AXI master tasks, bus peripheral model, watchdog
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "ps_bridge_defs.svh"

module tb_ps_sys_bridge
  import ps_bridge_pkg::*;
();

  localparam int N_TESTS = 6;  // watchdog allows 200 cycles per test

  logic      axi_clk, reset;
  axi_aw_t   aw;
  axi_w_t    w;
  axi_ar_t   ar;
  logic      awvalid, awready, wvalid, wready, arvalid, arready;
  axi_id_t   bid, rid;
  axi_resp_t bresp, rresp;
  axi_data_t rdata;
  logic      bvalid, bready, rvalid, rready;
  sys_req_t  sys_req;
  logic      sys_wen, sys_ren;
  sys_rsp_t  sys_rsp;

  int        cycle_cnt = 0;  // rising edges so far
  int        wen_cnt = 0;    // enable pulses seen
  int        ren_cnt = 0;
  int        en_cycle = 0;   // edge that raised the last enable
  sys_req_t  seen_req;       // request shown with the last enable

  ps_sys_bridge dut0 (
    .axi_clk_i (axi_clk), .reset_i (reset),
    .aw_i (aw), .awvalid_i (awvalid), .awready_o (awready),
    .w_i (w), .wvalid_i (wvalid), .wready_o (wready),
    .bid_o (bid), .bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready),
    .ar_i (ar), .arvalid_i (arvalid), .arready_o (arready),
    .rid_o (rid), .rdata_o (rdata), .rresp_o (rresp), .rvalid_o (rvalid),
    .rready_i (rready), .sys_req_o (sys_req), .sys_wen_o (sys_wen),
    .sys_ren_o (sys_ren), .sys_rsp_i (sys_rsp)
  );

  initial begin : clock_gen
    axi_clk = 1'b0;
    forever #10 axi_clk = ~axi_clk;  // 20 ns period
  end

  always @(posedge axi_clk) cycle_cnt <= cycle_cnt + 1;

  // enables sampled mid-cycle away from the drive point
  always @(negedge axi_clk) begin
    if (sys_wen || sys_ren) begin
      seen_req = sys_req;
      en_cycle = cycle_cnt;
    end
    if (sys_wen) wen_cnt++;
    if (sys_ren) ren_cnt++;
  end

  // peripheral model -------------
  initial begin : periph_model
    axi_addr_t acc_addr;
    int        delay;
    forever begin
      @(posedge axi_clk);
      #1;
      if (sys_wen || sys_ren) begin
        acc_addr = sys_req.addr;
        delay    = int'($urandom_range(3, 0));  // 0 to 3 cycles latency
        repeat (delay) begin
          @(posedge axi_clk);
          #1;
        end
        if (acc_addr[31:28] != 4'h8) begin      // region 8 stays silent
          sys_rsp.rdata = acc_addr ^ 32'hA5A5_0000;
          sys_rsp.err   = (acc_addr[31:28] == 4'h4);
          sys_rsp.ack   = 1'b1;
          @(posedge axi_clk);
          #1;
          sys_rsp = '0;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (N_TESTS * 200) @(posedge axi_clk);
    $display("ERROR: watchdog expired, a handshake or response never came");
    $display("Something failed");
    $fatal(1);
  end

  // checks -----------------------
  task automatic check_equal(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("CHECK FAILED: %s, %s expected %h actual %h", test, what, exp, act);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic check_true(input string test, input bit cond, input string what);
    assert (cond) else begin
      $display("ERROR: %s, %s", test, what);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  function automatic axi_addr_t region_addr(input logic [3:0] region);
    axi_addr_t rnd;
    rnd = $urandom;
    return {region, rnd[27:2], 2'b00};  // word aligned with the region in the top nibble
  endfunction

  // AXI master -------------------
  task automatic send_write(input axi_id_t id, input axi_addr_t addr,
                            input axi_data_t data, input axi_strb_t strb);
    logic aw_left;
    logic w_left;
    logic aw_take;
    logic w_take;
    aw.id   = id;
    aw.addr = addr;
    w.data  = data;
    w.strb  = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    aw_left = 1'b1;
    w_left  = 1'b1;
    while (aw_left || w_left) begin
      aw_take = aw_left & awready;  // ready holds until the next edge
      w_take  = w_left & wready;
      @(posedge axi_clk);
      #1;
      if (aw_take) begin
        aw_left = 1'b0;
        awvalid = 1'b0;
      end
      if (w_take) begin
        w_left = 1'b0;
        wvalid = 1'b0;
      end
    end
  endtask

  task automatic wait_bresp(output axi_id_t id, output axi_resp_t resp);
    bready = 1'b1;
    while (!bvalid) begin
      @(posedge axi_clk);
      #1;
    end
    id   = bid;
    resp = bresp;
    @(posedge axi_clk);  // handshake edge
    #1;
    bready = 1'b0;
  endtask

  task automatic axi_write(input axi_id_t id, input axi_addr_t addr, input axi_data_t data,
                           input axi_strb_t strb, output axi_id_t got_id,
                           output axi_resp_t got_resp);
    send_write(id, addr, data, strb);
    wait_bresp(got_id, got_resp);
  endtask

  task automatic axi_read(input axi_id_t id, input axi_addr_t addr, output axi_id_t got_id,
                          output axi_data_t got_data, output axi_resp_t got_resp,
                          output int cyc);
    logic take;
    ar.id   = id;
    ar.addr = addr;
    arvalid = 1'b1;
    take    = 1'b0;
    while (!take) begin
      take = arready;
      @(posedge axi_clk);
      #1;
    end
    arvalid = 1'b0;
    rready  = 1'b1;
    while (!rvalid) begin
      @(posedge axi_clk);
      #1;
    end
    got_id   = rid;
    got_data = rdata;
    got_resp = rresp;
    cyc      = cycle_cnt;  // edge that raised rvalid
    @(posedge axi_clk);
    #1;
    rready = 1'b0;
  endtask

  // tests ------------------------
  task automatic reset_values();
    check_equal("reset", "bvalid", 32'h0, 32'(bvalid));
    check_equal("reset", "rvalid", 32'h0, 32'(rvalid));
    check_equal("reset", "sys_wen", 32'h0, 32'(sys_wen));
    check_equal("reset", "sys_ren", 32'h0, 32'(sys_ren));
    check_equal("reset", "readies", 32'h0, 32'({awready, wready, arready}));
    @(posedge axi_clk);
    #1;
    check_equal("reset", "readies", 32'h7, 32'({awready, wready, arready}));
  endtask

  task automatic single_writes();
    axi_id_t   id;
    axi_addr_t addr;
    axi_data_t data;
    axi_strb_t strb;
    axi_id_t   got_id;
    axi_resp_t got_resp;
    int        wen0;
    for (int i = 0; i < 10; i++) begin
      id   = axi_id_t'($urandom);
      addr = region_addr(4'($urandom_range(3, 0)));
      data = $urandom;
      strb = axi_strb_t'($urandom);
      wen0 = wen_cnt;
      axi_write(id, addr, data, strb, got_id, got_resp);
      check_equal("write", "wen pulses", 32'(wen0 + 1), 32'(wen_cnt));
      check_equal("write", "sys addr", addr, seen_req.addr);
      check_equal("write", "sys wdata", data, seen_req.wdata);
      check_equal("write", "sys sel", 32'(strb), 32'(seen_req.sel));
      check_equal("write", "bresp", 32'(`PSB_RESP_OKAY), 32'(got_resp));
      check_equal("write", "bid", 32'(id), 32'(got_id));
    end
  endtask

  task automatic single_reads();
    axi_id_t   id;
    axi_addr_t addr;
    axi_id_t   got_id;
    axi_data_t got_data;
    axi_resp_t got_resp;
    int        cyc;
    int        ren0;
    for (int i = 0; i < 10; i++) begin
      id   = axi_id_t'($urandom);
      addr = region_addr(4'($urandom_range(3, 0)));
      ren0 = ren_cnt;
      axi_read(id, addr, got_id, got_data, got_resp, cyc);
      check_equal("read", "rdata", addr ^ 32'hA5A5_0000, got_data);
      check_equal("read", "rresp", 32'(`PSB_RESP_OKAY), 32'(got_resp));
      check_equal("read", "rid", 32'(id), 32'(got_id));
      check_equal("read", "ren pulses", 32'(ren0 + 1), 32'(ren_cnt));
    end
  endtask

  task automatic error_region();
    axi_id_t   got_id;
    axi_data_t got_data;
    axi_resp_t got_resp;
    int        cyc;
    axi_read(12'h4A1, region_addr(4'h4), got_id, got_data, got_resp, cyc);
    check_equal("error", "rresp", 32'(`PSB_RESP_SLVERR), 32'(got_resp));
    check_equal("error", "rdata", 32'h0, got_data);
    check_equal("error", "rid", 32'h4A1, 32'(got_id));
    axi_write(12'h4B2, region_addr(4'h4), $urandom, 4'hF, got_id, got_resp);
    check_equal("error", "bresp", 32'(`PSB_RESP_SLVERR), 32'(got_resp));
    check_equal("error", "bid", 32'h4B2, 32'(got_id));
  endtask

  task automatic ack_timeout();
    axi_id_t   got_id;
    axi_data_t got_data;
    axi_resp_t got_resp;
    int        cyc;
    axi_read(12'h8C3, region_addr(4'h8), got_id, got_data, got_resp, cyc);
    check_equal("timeout", "rresp", 32'(`PSB_RESP_SLVERR), 32'(got_resp));
    check_equal("timeout", "rdata", 32'h0, got_data);
    check_equal("timeout", "rid", 32'h8C3, 32'(got_id));
    check_true("timeout", (cyc - en_cycle) >= `PSB_SYS_TIMEOUT,
               "the response came before the ack timeout");
  endtask

  task automatic write_backpressure();
    axi_addr_t addr2;
    axi_id_t   got_id;
    axi_resp_t got_resp;
    int        wen0;
    addr2 = region_addr(4'h2);
    send_write(12'h111, region_addr(4'h1), $urandom, 4'hF);
    while (!bvalid) begin  // bready stays low
      @(posedge axi_clk);
      #1;
    end
    wen0 = wen_cnt;
    send_write(12'h222, addr2, $urandom, 4'h3);  // lands in the free slots
    repeat (8) @(posedge axi_clk);
    #1;
    check_equal("backpressure", "wen pulses while blocked", 32'(wen0), 32'(wen_cnt));
    check_equal("backpressure", "bvalid while blocked", 32'h1, 32'(bvalid));
    check_equal("backpressure", "awready while blocked", 32'h0, 32'(awready));
    wait_bresp(got_id, got_resp);
    check_equal("backpressure", "first bid", 32'h111, 32'(got_id));
    check_equal("backpressure", "first bresp", 32'(`PSB_RESP_OKAY), 32'(got_resp));
    wait_bresp(got_id, got_resp);
    check_equal("backpressure", "second bid", 32'h222, 32'(got_id));
    check_equal("backpressure", "second bresp", 32'(`PSB_RESP_OKAY), 32'(got_resp));
    check_equal("backpressure", "wen pulses", 32'(wen0 + 1), 32'(wen_cnt));
    check_equal("backpressure", "second addr", addr2, seen_req.addr);
  endtask

  // main sequence ----------------
  initial begin : main_seq
    void'($urandom(27));
    reset   = 1'b1;
    aw      = '0;
    w       = '0;
    ar      = '0;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b0;
    bready  = 1'b0;
    rready  = 1'b0;
    sys_rsp = '0;
    repeat (2) @(posedge axi_clk);
    #1;
    reset = 1'b0;
    reset_values();
    single_writes();
    single_reads();
    error_region();
    ack_timeout();
    write_backpressure();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
ps_bridge_pkg.sv
axi_req_capture.sv
axi_bridge_ctrl.sv
sys_bus_timer.sv
axi_resp_gen.sv
ps_sys_bridge.sv
tb_ps_sys_bridge.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := tb_ps_sys_bridge
FLIST     := flist.f
OBJ_DIR   := obj_dir
PASS_MSG  := Everything OK

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FLIST))) $(wildcard *.svh)

.PHONY: all run clean

all: run

# rebuild only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FLIST)

# status comes from the search for the pass message
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
